/* chip8_top.f */
+incdir+include
design/chip8_mem_pkg.sv
design/chip8_isa_pkg.sv
design/mem_port_if.sv
design/draw_cmd_if.sv
design/chip8_ram.sv
design/mem_arbiter.sv
design/chip8_core.sv
design/display_engine.sv
design/chip8_top.sv
tests/chip8_tb.sv

/* design/chip8_core.sv */
`timescale 1ns/1ps
`default_nettype none

module chip8_core (
  input  wire           clk,
  input  wire           arst_n,
  input  wire           start,
  output logic          halted,
  mem_port_if.requester mem,
  draw_cmd_if.core      draw
);
  import chip8_mem_pkg::*;
  import chip8_isa_pkg::*;

  typedef enum logic [3:0] {
    S_STOP,
    S_FETCH_HI,
    S_FETCH_LO,
    S_LOAD_VX,
    S_LOAD_VY,
    S_LOAD_V0,
    S_EXEC,
    S_STORE_VX,
    S_STORE_VF,
    S_PUSH_HI,
    S_PUSH_LO,
    S_POP_HI,
    S_POP_LO,
    S_DRAW,
    S_DRAW_WAIT
  } state_e;

  state_e     state;
  logic       rd_wait;
  addr_t      pc;
  addr_t      i_reg;
  addr_t      ret_pc;
  logic [3:0] sp;
  instr_t     ir;
  byte_t      vx;
  byte_t      vy;
  byte_t      new_vx;
  logic       carry;
  logic       use_carry;
  logic       skip;
  logic       rd_state;
  logic       wr_state;
  addr_t      nnn;
  byte_t      kk;

  assign nnn = {ir.x, ir.y, ir.n};
  assign kk  = {ir.y, ir.n};

  assign rd_state = state inside {S_FETCH_HI, S_FETCH_LO, S_LOAD_VX, S_LOAD_VY, S_LOAD_V0,
                                  S_POP_HI, S_POP_LO};
  assign wr_state = state inside {S_STORE_VX, S_STORE_VF, S_PUSH_HI, S_PUSH_LO};

  assign mem.valid = (rd_state && !rd_wait) || wr_state;
  assign mem.write = wr_state;

  always_comb begin
    case (state)
      S_FETCH_LO: mem.addr = pc + 12'd1;
      S_LOAD_VX:  mem.addr = REG_BASE + addr_t'(ir.x);
      S_LOAD_VY:  mem.addr = REG_BASE + addr_t'(ir.y);
      S_LOAD_V0:  mem.addr = REG_BASE;
      S_STORE_VX: mem.addr = REG_BASE + addr_t'(ir.x);
      S_STORE_VF: mem.addr = REG_BASE + 12'hF;
      S_PUSH_HI,
      S_POP_HI:   mem.addr = STACK_BASE + addr_t'({sp, 1'b0});
      S_PUSH_LO,
      S_POP_LO:   mem.addr = STACK_BASE + addr_t'({sp, 1'b1});
      default:    mem.addr = pc;
    endcase
  end

  always_comb begin
    case (state)
      S_PUSH_HI:  mem.wdata = byte_t'(ret_pc[11:8]);
      S_PUSH_LO:  mem.wdata = ret_pc[7:0];
      S_STORE_VF: mem.wdata = byte_t'(carry);
      default:    mem.wdata = new_vx;
    endcase
  end

  always_comb begin
    case (ir.op)
      OP_SE_K:  skip = (vx == kk);
      OP_SNE_K: skip = (vx != kk);
      OP_SE_V:  skip = (vx == vy);
      OP_SNE_V: skip = (vx != vy);
      default:  skip = 1'b0;
    endcase
  end

  // CLS reuses the draw command with clear set
  assign draw.valid       = (state == S_DRAW);
  assign draw.clear       = (ir.op == OP_SYS);
  assign draw.sprite_addr = i_reg;
  assign draw.lines       = ir.n;
  assign draw.x           = vx[5:0];
  assign draw.y           = vy[4:0];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= S_STOP;
      halted    <= 1'b0;
      rd_wait   <= 1'b0;
      pc        <= PROG_START;
      i_reg     <= '0;
      ret_pc    <= '0;
      sp        <= '0;
      ir        <= '0;
      vx        <= '0;
      vy        <= '0;
      new_vx    <= '0;
      carry     <= 1'b0;
      use_carry <= 1'b0;
    end else begin
      if (mem.valid && mem.ready && !mem.write) begin
        rd_wait <= 1'b1;
      end
      if (mem.rvalid) begin
        rd_wait <= 1'b0;
      end

      case (state)
        S_STOP: begin
          if (start) begin
            halted <= 1'b0;
            pc     <= PROG_START;
            sp     <= '0;
            state  <= S_FETCH_HI;
          end
        end
        S_FETCH_HI: begin
          if (mem.rvalid) begin
            ir[15:8] <= mem.rdata;
            state    <= S_FETCH_LO;
          end
        end
        S_FETCH_LO: begin
          if (mem.rvalid) begin
            ir[7:0] <= mem.rdata;
            state   <= (ir.op == OP_JP_V0) ? S_LOAD_V0 : S_LOAD_VX;
          end
        end
        S_LOAD_VX: begin
          if (mem.rvalid) begin
            vx    <= mem.rdata;
            state <= S_LOAD_VY;
          end
        end
        S_LOAD_VY,
        S_LOAD_V0: begin
          if (mem.rvalid) begin
            if (state == S_LOAD_VY) begin
              vy <= mem.rdata;
            end else begin
              vx <= mem.rdata;
            end
            state <= S_EXEC;
          end
        end
        S_EXEC: begin
          pc        <= skip ? pc + 12'd4 : pc + 12'd2;
          use_carry <= 1'b0;
          state     <= S_FETCH_HI;
          case (ir.op)
            OP_SYS: begin
              if (nnn == OP_CLS) begin
                state <= S_DRAW;
              end else if (nnn == OP_RET) begin
                sp    <= sp - 4'd1;
                state <= S_POP_HI;
              end else if (nnn == OP_EXIT) begin
                halted <= 1'b1;
                state  <= S_STOP;
              end
            end
            OP_JP:    pc <= nnn;
            OP_JP_V0: pc <= nnn + addr_t'(vx);
            OP_CALL: begin
              ret_pc <= pc + 12'd2;
              pc     <= nnn;
              state  <= S_PUSH_HI;
            end
            OP_LD_K: begin
              new_vx <= kk;
              state  <= S_STORE_VX;
            end
            OP_ADD_K: begin
              new_vx <= vx + kk;
              state  <= S_STORE_VX;
            end
            OP_ALU: begin
              state     <= S_STORE_VX;
              use_carry <= 1'b1;
              case (alu_e'(ir.n))
                ALU_LD: begin
                  new_vx    <= vy;
                  use_carry <= 1'b0;
                end
                ALU_OR: begin
                  new_vx    <= vx | vy;
                  use_carry <= 1'b0;
                end
                ALU_AND: begin
                  new_vx    <= vx & vy;
                  use_carry <= 1'b0;
                end
                ALU_XOR: begin
                  new_vx    <= vx ^ vy;
                  use_carry <= 1'b0;
                end
                ALU_ADD:  {carry, new_vx} <= {1'b0, vx} + {1'b0, vy};
                ALU_SUB: begin
                  new_vx <= vx - vy;
                  carry  <= (vx > vy);
                end
                ALU_SUBN: begin
                  new_vx <= vy - vx;
                  carry  <= (vy > vx);
                end
                ALU_SHR: begin
                  new_vx <= {1'b0, vx[7:1]};
                  carry  <= vx[0];
                end
                ALU_SHL: begin
                  new_vx <= {vx[6:0], 1'b0};
                  carry  <= vx[7];
                end
                default: begin
                  use_carry <= 1'b0;
                  state     <= S_FETCH_HI;
                end
              endcase
            end
            OP_LD_I: i_reg <= nnn;
            OP_DRW:  state <= S_DRAW;
            OP_MISC: begin
              if (kk == FN_ADD_I) begin
                i_reg <= i_reg + addr_t'(vx);
              end
            end
            default: ;
          endcase
        end
        S_STORE_VX: begin
          if (mem.ready) begin
            state <= use_carry ? S_STORE_VF : S_FETCH_HI;
          end
        end
        S_STORE_VF: begin
          if (mem.ready) begin
            state <= S_FETCH_HI;
          end
        end
        S_PUSH_HI: begin
          if (mem.ready) begin
            state <= S_PUSH_LO;
          end
        end
        S_PUSH_LO: begin
          if (mem.ready) begin
            sp    <= sp + 4'd1;
            state <= S_FETCH_HI;
          end
        end
        S_POP_HI: begin
          if (mem.rvalid) begin
            pc[11:8] <= mem.rdata[3:0];
            state    <= S_POP_LO;
          end
        end
        S_POP_LO: begin
          if (mem.rvalid) begin
            pc[7:0] <= mem.rdata;
            state   <= S_FETCH_HI;
          end
        end
        S_DRAW: begin
          if (draw.ready) begin
            state <= S_DRAW_WAIT;
          end
        end
        S_DRAW_WAIT: begin
          if (draw.done) begin
            carry <= draw.collision;
            state <= draw.clear ? S_FETCH_HI : S_STORE_VF;
          end
        end
        default: state <= S_STOP;
      endcase
    end
  end

  a_req_stable: assert property (@(posedge clk) disable iff (!arst_n)
    mem.valid && !mem.ready |=> mem.valid && $stable(mem.write) && $stable(mem.addr)
      && $stable(mem.wdata))
    else $error("core memory request changed while stalled");

endmodule

`default_nettype wire

/* design/chip8_isa_pkg.sv */
`default_nettype none

package chip8_isa_pkg;

  // Leading nibble of the opcode
  typedef enum logic [3:0] {
    OP_SYS    = 4'h0,
    OP_JP     = 4'h1,
    OP_CALL   = 4'h2,
    OP_SE_K   = 4'h3,
    OP_SNE_K  = 4'h4,
    OP_SE_V   = 4'h5,
    OP_LD_K   = 4'h6,
    OP_ADD_K  = 4'h7,
    OP_ALU    = 4'h8,
    OP_SNE_V  = 4'h9,
    OP_LD_I   = 4'hA,
    OP_JP_V0  = 4'hB,
    OP_RND    = 4'hC,
    OP_DRW    = 4'hD,
    OP_KEY    = 4'hE,
    OP_MISC   = 4'hF
  } op_e;

  // Low nibble of 8xy_
  typedef enum logic [3:0] {
    ALU_LD   = 4'h0,
    ALU_OR   = 4'h1,
    ALU_AND  = 4'h2,
    ALU_XOR  = 4'h3,
    ALU_ADD  = 4'h4,
    ALU_SUB  = 4'h5,
    ALU_SHR  = 4'h6,
    ALU_SUBN = 4'h7,
    ALU_SHL  = 4'hE
  } alu_e;

  typedef struct packed {
    op_e        op;
    logic [3:0] x;
    logic [3:0] y;
    logic [3:0] n;
  } instr_t;

  localparam logic [11:0] OP_CLS  = 12'h0E0;
  localparam logic [11:0] OP_RET  = 12'h0EE;
  localparam logic [11:0] OP_EXIT = 12'h0FD;

  // Fx1E
  localparam logic [7:0] FN_ADD_I = 8'h1E;

endpackage

`default_nettype wire

/* design/chip8_mem_pkg.sv */
`default_nettype none

package chip8_mem_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [11:0] addr_t;

  // 16 entries of two bytes, high byte first
  localparam addr_t STACK_BASE = 12'h000;

  // V0 to VF
  localparam addr_t REG_BASE = 12'h020;

  // 32 rows of 8 bytes, MSB is the leftmost pixel
  localparam addr_t SCREEN_BASE = 12'h100;
  localparam int SCREEN_BYTES = 256;

  localparam addr_t PROG_START = 12'h200;

  // Lower index wins arbitration
  localparam int PORT_DISPLAY = 0;
  localparam int PORT_CORE    = 1;
  localparam int PORT_HOST    = 2;

endpackage

`default_nettype wire

/* design/chip8_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module chip8_ram #(
  parameter int DEPTH = 4096
) (
  input  wire                        clk,
  input  wire                        en,
  input  wire                        we,
  input  wire chip8_mem_pkg::addr_t  addr,
  input  wire chip8_mem_pkg::byte_t  wdata,
  output chip8_mem_pkg::byte_t       rdata
);
  import chip8_mem_pkg::*;

  byte_t mem [DEPTH];

  // Read data shows up one cycle after the access
  always_ff @(posedge clk) begin
    if (en) begin
      if (we) begin
        mem[addr] <= wdata;
      end else begin
        rdata <= mem[addr];
      end
    end
  end

endmodule

`default_nettype wire

/* design/chip8_top.sv */
`timescale 1ns/1ps
`default_nettype none

module chip8_top (
  input  wire                        clk,
  input  wire                        arst_n,
  input  wire                        start,
  output logic                       halted,
  input  wire                        host_valid,
  input  wire                        host_write,
  input  wire chip8_mem_pkg::addr_t  host_addr,
  input  wire chip8_mem_pkg::byte_t  host_wdata,
  output logic                       host_ready,
  output logic                       host_rvalid,
  output chip8_mem_pkg::byte_t       host_rdata
);
  import chip8_mem_pkg::*;

  localparam int N_PORTS   = 3;
  localparam int RAM_DEPTH = 4096;

  logic  ram_en;
  logic  ram_we;
  addr_t ram_addr;
  byte_t ram_wdata;
  byte_t ram_rdata;

  mem_port_if mem_bus [N_PORTS] ();
  draw_cmd_if draw_bus ();

  // Host access port
  assign mem_bus[PORT_HOST].valid = host_valid;
  assign mem_bus[PORT_HOST].write = host_write;
  assign mem_bus[PORT_HOST].addr  = host_addr;
  assign mem_bus[PORT_HOST].wdata = host_wdata;
  assign host_ready  = mem_bus[PORT_HOST].ready;
  assign host_rvalid = mem_bus[PORT_HOST].rvalid;
  assign host_rdata  = mem_bus[PORT_HOST].rdata;

  chip8_core u_core (
    .clk    (clk),
    .arst_n (arst_n),
    .start  (start),
    .halted (halted),
    .mem    (mem_bus[PORT_CORE]),
    .draw   (draw_bus)
  );

  display_engine u_display (
    .clk    (clk),
    .arst_n (arst_n),
    .cmd    (draw_bus),
    .mem    (mem_bus[PORT_DISPLAY])
  );

  mem_arbiter #(
    .N_PORTS (N_PORTS)
  ) u_arbiter (
    .clk       (clk),
    .arst_n    (arst_n),
    .ports     (mem_bus),
    .ram_en    (ram_en),
    .ram_we    (ram_we),
    .ram_addr  (ram_addr),
    .ram_wdata (ram_wdata),
    .ram_rdata (ram_rdata)
  );

  chip8_ram #(
    .DEPTH (RAM_DEPTH)
  ) u_ram (
    .clk   (clk),
    .en    (ram_en),
    .we    (ram_we),
    .addr  (ram_addr),
    .wdata (ram_wdata),
    .rdata (ram_rdata)
  );

endmodule

`default_nettype wire

/* design/display_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module display_engine (
  input  wire           clk,
  input  wire           arst_n,
  draw_cmd_if.engine    cmd,
  mem_port_if.requester mem
);
  import chip8_mem_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE,
    S_CLEAR,
    S_SPR,
    S_SCR0,
    S_SCR1,
    S_WR0,
    S_WR1,
    S_DONE
  } state_e;

  state_e      state;
  logic        rd_wait;
  logic        collision;
  logic [7:0]  clr_idx;
  logic [3:0]  row;
  addr_t       spr_addr;
  logic [3:0]  lines;
  logic [5:0]  x;
  logic [4:0]  y;
  byte_t       spr;
  byte_t       scr0;
  byte_t       scr1;
  logic [15:0] shifted;
  logic [4:0]  scr_row;
  logic [2:0]  col0;
  logic [2:0]  col1;
  logic        rd_state;
  logic        wr_state;

  // Second byte wraps to column 0 of the same row
  assign scr_row = y + 5'(row);
  assign col0    = x[5:3];
  assign col1    = col0 + 3'd1;
  assign shifted = {spr, 8'h00} >> x[2:0];

  assign rd_state  = state inside {S_SPR, S_SCR0, S_SCR1};
  assign wr_state  = state inside {S_CLEAR, S_WR0, S_WR1};
  assign mem.valid = (rd_state && !rd_wait) || wr_state;
  assign mem.write = wr_state;

  always_comb begin
    case (state)
      S_CLEAR:     mem.addr = SCREEN_BASE + addr_t'(clr_idx);
      S_SPR:       mem.addr = spr_addr + addr_t'(row);
      S_SCR1,
      S_WR1:       mem.addr = SCREEN_BASE + addr_t'({scr_row, col1});
      default:     mem.addr = SCREEN_BASE + addr_t'({scr_row, col0});
    endcase
  end

  always_comb begin
    case (state)
      S_WR0:   mem.wdata = scr0 ^ shifted[15:8];
      S_WR1:   mem.wdata = scr1 ^ shifted[7:0];
      default: mem.wdata = '0;
    endcase
  end

  assign cmd.ready     = (state == S_IDLE);
  assign cmd.done      = (state == S_DONE);
  assign cmd.collision = collision;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= S_IDLE;
      rd_wait   <= 1'b0;
      collision <= 1'b0;
      clr_idx   <= '0;
      row       <= '0;
    end else begin
      if (mem.valid && mem.ready && !mem.write) begin
        rd_wait <= 1'b1;
      end
      if (mem.rvalid) begin
        rd_wait <= 1'b0;
      end

      case (state)
        S_IDLE: begin
          if (cmd.valid) begin
            collision <= 1'b0;
            clr_idx   <= '0;
            row       <= '0;
            if (cmd.clear) begin
              state <= S_CLEAR;
            end else begin
              state <= (cmd.lines == 4'd0) ? S_DONE : S_SPR;
            end
          end
        end
        S_CLEAR: begin
          if (mem.ready) begin
            clr_idx <= clr_idx + 8'd1;
            if (clr_idx == 8'(SCREEN_BYTES - 1)) begin
              state <= S_DONE;
            end
          end
        end
        S_SPR: begin
          if (mem.rvalid) begin
            state <= S_SCR0;
          end
        end
        S_SCR0: begin
          if (mem.rvalid) begin
            state <= S_SCR1;
          end
        end
        S_SCR1: begin
          if (mem.rvalid) begin
            // A lit pixel under a sprite bit turns off
            collision <= collision | (|(scr0 & shifted[15:8])) | (|(mem.rdata & shifted[7:0]));
            state     <= S_WR0;
          end
        end
        S_WR0: begin
          if (mem.ready) begin
            state <= S_WR1;
          end
        end
        S_WR1: begin
          if (mem.ready) begin
            if (row == lines - 4'd1) begin
              state <= S_DONE;
            end else begin
              row   <= row + 4'd1;
              state <= S_SPR;
            end
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_IDLE && cmd.valid) begin
      spr_addr <= cmd.sprite_addr;
      lines    <= cmd.lines;
      x        <= cmd.x;
      y        <= cmd.y;
    end
    if (mem.rvalid) begin
      case (state)
        S_SPR:   spr  <= mem.rdata;
        S_SCR0:  scr0 <= mem.rdata;
        S_SCR1:  scr1 <= mem.rdata;
        default: ;
      endcase
    end
  end

  a_no_cmd_busy: assert property (@(posedge clk) disable iff (!arst_n)
    (state != S_IDLE) |-> !cmd.valid)
    else $error("draw command issued while the engine is busy");

endmodule

`default_nettype wire

/* design/draw_cmd_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface draw_cmd_if;
  import chip8_mem_pkg::*;

  logic       valid;
  logic       clear;
  addr_t      sprite_addr;
  logic [3:0] lines;
  logic [5:0] x;
  logic [4:0] y;
  logic       ready;
  logic       done;
  logic       collision;

  modport core (
    output valid, clear, sprite_addr, lines, x, y,
    input  ready, done, collision
  );

  modport engine (
    input  valid, clear, sprite_addr, lines, x, y,
    output ready, done, collision
  );

endinterface

`default_nettype wire

/* design/mem_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter #(
  parameter int N_PORTS = 3
) (
  input  wire                        clk,
  input  wire                        arst_n,
  mem_port_if.arbiter                ports [N_PORTS],
  output logic                       ram_en,
  output logic                       ram_we,
  output chip8_mem_pkg::addr_t       ram_addr,
  output chip8_mem_pkg::byte_t       ram_wdata,
  input  wire chip8_mem_pkg::byte_t  ram_rdata
);
  import chip8_mem_pkg::*;

  logic [N_PORTS-1:0] req;
  logic [N_PORTS-1:0] req_write;
  logic [N_PORTS-1:0] grant;
  logic [N_PORTS-1:0] rd_owner;
  addr_t              req_addr  [N_PORTS];
  byte_t              req_wdata [N_PORTS];

  for (genvar i = 0; i < N_PORTS; i++) begin : g_port
    assign req[i]       = ports[i].valid;
    assign req_write[i] = ports[i].write;
    assign req_addr[i]  = ports[i].addr;
    assign req_wdata[i] = ports[i].wdata;

    assign ports[i].ready  = grant[i];
    assign ports[i].rvalid = rd_owner[i];
    assign ports[i].rdata  = rd_owner[i] ? ram_rdata : '0;

    // Returned data must come from a RAM read of this port's own address
    a_rvalid_after_read: assert property (@(posedge clk) disable iff (!arst_n)
      ports[i].rvalid |-> $past(ram_en && !ram_we && ports[i].valid
        && (ram_addr == ports[i].addr)))
      else $error("rvalid on port %0d without a RAM read for it", i);
  end

  // Lowest set bit of the request vector
  assign grant = req & (~req + 1'b1);

  always_comb begin
    ram_en    = |grant;
    ram_we    = 1'b0;
    ram_addr  = '0;
    ram_wdata = '0;
    for (int i = 0; i < N_PORTS; i++) begin
      if (grant[i]) begin
        ram_we    = req_write[i];
        ram_addr  = req_addr[i];
        ram_wdata = req_wdata[i];
      end
    end
  end

  // Owner of the read whose data arrives next cycle
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_owner <= '0;
    end else begin
      rd_owner <= grant & ~req_write;
    end
  end

  a_one_grant: assert property (@(posedge clk) disable iff (!arst_n)
    $onehot0(grant) && ((grant & ~req) == '0))
    else $error("bad grant %b for requests %b", grant, req);

endmodule

`default_nettype wire

/* design/mem_port_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface mem_port_if;
  import chip8_mem_pkg::*;

  logic  valid;
  logic  write;
  addr_t addr;
  byte_t wdata;
  logic  ready;
  logic  rvalid;
  byte_t rdata;

  modport requester (
    output valid, write, addr, wdata,
    input  ready, rvalid, rdata
  );

  modport arbiter (
    input  valid, write, addr, wdata,
    output ready, rvalid, rdata
  );

endinterface

`default_nettype wire

/* include/chip8_tb_checks.svh */
`ifndef CHIP8_TB_CHECKS_SVH
`define CHIP8_TB_CHECKS_SVH

task automatic check_byte(input string name, input byte_t got, input byte_t exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("** Error: %s = 0x%02h, expected 0x%02h", name, got, exp);
  end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
  end
endtask

// Ready is sampled a quarter period after the falling edge, before the rising edge
task automatic host_access(input logic wr, input addr_t a, input byte_t d, output logic ok);
  int cycles;
  @(negedge clk);
  host_valid = 1'b1;
  host_write = wr;
  host_addr  = a;
  host_wdata = d;
  ok     = 1'b0;
  cycles = 0;
  while (!ok && cycles < ACCESS_TIMEOUT) begin
    #(CLK_PERIOD / 4);
    ok = host_ready;
    @(negedge clk);
    cycles++;
  end
  host_valid = 1'b0;
  host_write = 1'b0;
  if (!ok) begin
    errors++;
    $display("Host access to 0x%03h was never accepted", a);
  end
endtask

task automatic host_write_byte(input addr_t a, input byte_t d);
  logic ok;
  host_access(1'b1, a, d, ok);
endtask

task automatic host_read_byte(input addr_t a, output byte_t d);
  logic ok;
  int   cycles;
  d = 'x;
  host_access(1'b0, a, '0, ok);
  cycles = 0;
  while (ok && !host_rvalid && cycles < ACCESS_TIMEOUT) begin
    @(negedge clk);
    cycles++;
  end
  if (ok && !host_rvalid) begin
    errors++;
    $display("Host read of 0x%03h returned no data", a);
  end else if (ok) begin
    d = host_rdata;
  end
endtask

task automatic expect_mem(input addr_t a, input byte_t exp, input string name);
  byte_t got;
  host_read_byte(a, got);
  check_byte(name, got, exp);
endtask

// High byte of each instruction at the lower address
task automatic load_program();
  logic [15:0] w;
  int          i;
  for (i = 0; i < prog.size(); i++) begin
    w = prog[i];
    host_write_byte(PROG_START + addr_t'(2 * i), w[15:8]);
    host_write_byte(PROG_START + addr_t'(2 * i + 1), w[7:0]);
  end
endtask

task automatic pulse_start();
  @(negedge clk);
  start = 1'b1;
  @(negedge clk);
  start = 1'b0;
endtask

task automatic wait_halt();
  int cycles;
  cycles = 0;
  while (!halted && cycles < HALT_TIMEOUT) begin
    @(negedge clk);
    cycles++;
  end
  if (!halted) begin
    errors++;
    $display("The core did not halt within %0d cycles", HALT_TIMEOUT);
  end
endtask

task automatic run_to_halt();
  pulse_start();
  wait_halt();
endtask

`endif

/* tests/chip8_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module chip8_tb;
  import chip8_mem_pkg::*;
  import chip8_isa_pkg::*;

  localparam int    CLK_PERIOD     = 100;
  localparam int    ACCESS_TIMEOUT = 1000;
  localparam int    HALT_TIMEOUT   = 100000;
  localparam addr_t SPRITE_ADDR    = 12'h300;
  localparam addr_t PROBE_ADDR     = 12'h400;

  logic  clk = 1'b0;
  logic  arst_n;
  logic  start;
  logic  halted;
  logic  host_valid;
  logic  host_write;
  addr_t host_addr;
  byte_t host_wdata;
  logic  host_ready;
  logic  host_rvalid;
  byte_t host_rdata;

  integer seed = 32'he639;
  int     errors = 0;
  int     checks = 0;
  int     tests_run = 0;
  int     tests_failed = 0;
  instr_t prog [$];
  byte_t  v [16];
  byte_t  scr_model [SCREEN_BYTES];
  byte_t  sprite [2];

  always #(CLK_PERIOD / 2) clk = ~clk;

  chip8_top u_dut (
    .clk         (clk),
    .arst_n      (arst_n),
    .start       (start),
    .halted      (halted),
    .host_valid  (host_valid),
    .host_write  (host_write),
    .host_addr   (host_addr),
    .host_wdata  (host_wdata),
    .host_ready  (host_ready),
    .host_rvalid (host_rvalid),
    .host_rdata  (host_rdata)
  );

  `include "chip8_tb_checks.svh"

  task automatic emit(input logic [15:0] w);
    prog.push_back(instr_t'(w));
  endtask

  function automatic addr_t next_addr();
    return PROG_START + addr_t'(2 * prog.size());
  endfunction

  // Pad with 0000 words that run as NOPs
  task automatic pad_to(input addr_t a);
    while (next_addr() < a) begin
      emit(16'h0000);
    end
  endtask

  task automatic ld_imm(input int x, input byte_t k);
    emit({4'h6, 4'(x), k});
    v[x] = k;
  endtask

  task automatic add_imm(input int x, input byte_t k);
    emit({4'h7, 4'(x), k});
    v[x] = v[x] + k;
  endtask

  task automatic alu_op(input int x, input int y, input alu_e fn);
    byte_t a;
    byte_t b;
    byte_t r;
    logic  flag;
    logic  sets_flag;
    emit({4'h8, 4'(x), 4'(y), fn});
    a         = v[x];
    b         = v[y];
    flag      = 1'b0;
    sets_flag = 1'b1;
    case (fn)
      ALU_LD: begin
        r         = b;
        sets_flag = 1'b0;
      end
      ALU_OR: begin
        r         = a | b;
        sets_flag = 1'b0;
      end
      ALU_AND: begin
        r         = a & b;
        sets_flag = 1'b0;
      end
      ALU_XOR: begin
        r         = a ^ b;
        sets_flag = 1'b0;
      end
      ALU_ADD: begin
        r    = a + b;
        flag = (int'(a) + int'(b)) >= 256;
      end
      ALU_SUB: begin
        r    = a - b;
        flag = (a > b);
      end
      ALU_SUBN: begin
        r    = b - a;
        flag = (b > a);
      end
      ALU_SHR: begin
        r    = a >> 1;
        flag = a[0];
      end
      ALU_SHL: begin
        r    = a << 1;
        flag = a[7];
      end
      default: begin
        r         = a;
        sets_flag = 1'b0;
      end
    endcase
    // VF written last wins when x is F
    v[x] = r;
    if (sets_flag) begin
      v[15] = byte_t'(flag);
    end
  endtask

  // Marker register is set only on the fall-through path
  task automatic skip_then_mark(input logic [15:0] skip_instr, input logic taken, input int m);
    emit(skip_instr);
    if (taken) begin
      emit({4'h6, 4'(m), 8'h01});
    end else begin
      ld_imm(m, 8'h01);
    end
  endtask

  task automatic clear_regs();
    int i;
    for (i = 0; i < 16; i++) begin
      host_write_byte(REG_BASE + addr_t'(i), 8'h00);
      v[i] = 8'h00;
    end
  endtask

  task automatic check_regs();
    int i;
    for (i = 0; i < 16; i++) begin
      expect_mem(REG_BASE + addr_t'(i), v[i], $sformatf("V%0h", i));
    end
  endtask

  // Pixel by pixel XOR with wrap on both axes
  task automatic draw_model(input int x, input int y, output logic hit);
    int r;
    int b;
    int col;
    int idx;
    hit = 1'b0;
    for (r = 0; r < 2; r++) begin
      for (b = 0; b < 8; b++) begin
        if (sprite[r][7 - b]) begin
          col = (x + b) % 64;
          idx = ((y + r) % 32) * 8 + col / 8;
          if (scr_model[idx][7 - col % 8]) begin
            hit = 1'b1;
          end
          scr_model[idx][7 - col % 8] = ~scr_model[idx][7 - col % 8];
        end
      end
    end
  endtask

  task automatic check_screen();
    int i;
    for (i = 0; i < SCREEN_BYTES; i++) begin
      expect_mem(SCREEN_BASE + addr_t'(i), scr_model[i], $sformatf("screen[0x%02h]", i));
    end
  endtask

  task automatic end_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: failed with %0d errors", name, errors - errors_before);
    end
  endtask

  task automatic test_host_port();
    addr_t a [8];
    byte_t d [8];
    int    i;
    int    err0;
    err0 = errors;
    // Eight 0x1A0 slices span 0x300 to 0xFFF with one address each
    for (i = 0; i < 8; i++) begin
      a[i] = 12'h300 + addr_t'(i * 12'h1A0) + addr_t'({$random(seed)} % 12'h1A0);
      d[i] = byte_t'($random(seed));
      host_write_byte(a[i], d[i]);
    end
    for (i = 0; i < 8; i++) begin
      expect_mem(a[i], d[i], $sformatf("mem[0x%03h]", a[i]));
    end
    check_flag("halted", halted, 1'b0);
    end_test("host_port", err0);
  endtask

  task automatic test_arithmetic();
    int err0;
    err0 = errors;
    prog.delete();
    clear_regs();
    ld_imm(0, byte_t'($random(seed)));
    ld_imm(1, byte_t'($random(seed)));
    alu_op(2, 0, ALU_LD);
    add_imm(2, byte_t'($random(seed)));
    alu_op(3, 0, ALU_LD);
    alu_op(3, 1, ALU_OR);
    alu_op(4, 0, ALU_LD);
    alu_op(4, 1, ALU_AND);
    alu_op(5, 0, ALU_LD);
    alu_op(5, 1, ALU_XOR);
    alu_op(6, 0, ALU_LD);
    alu_op(6, 1, ALU_ADD);
    alu_op(7, 0, ALU_LD);
    alu_op(7, 1, ALU_SUB);
    alu_op(8, 0, ALU_LD);
    alu_op(8, 1, ALU_SHR);
    alu_op(9, 0, ALU_LD);
    alu_op(9, 1, ALU_SUBN);
    alu_op(10, 0, ALU_LD);
    alu_op(10, 1, ALU_SHL);
    alu_op(15, 1, ALU_ADD);
    emit({4'h0, OP_EXIT});
    load_program();
    run_to_halt();
    check_regs();
    end_test("arithmetic", err0);
  endtask

  task automatic test_control_flow();
    int    err0;
    addr_t ret_addr;
    addr_t target;
    err0 = errors;
    prog.delete();
    clear_regs();
    ld_imm(0, 8'h05);
    ld_imm(1, 8'h05);
    ld_imm(2, 8'h07);
    skip_then_mark(16'h3005, v[0] == 8'h05, 3);
    skip_then_mark(16'h3006, v[0] == 8'h06, 4);
    skip_then_mark(16'h4006, v[0] != 8'h06, 5);
    skip_then_mark(16'h4005, v[0] != 8'h05, 6);
    skip_then_mark(16'h5010, v[0] == v[1], 7);
    skip_then_mark(16'h5020, v[0] == v[2], 8);
    skip_then_mark(16'h9020, v[0] != v[2], 9);
    skip_then_mark(16'h9010, v[0] != v[1], 10);
    ret_addr = next_addr() + 12'd2;
    emit(16'h2240);
    target = 12'h24B + addr_t'(v[0]);
    emit(16'hB24B);
    // Jumped over so VC stays 0
    emit(16'h6C01);
    emit({4'h0, OP_EXIT});
    pad_to(12'h240);
    ld_imm(11, 8'h01);
    emit({4'h0, OP_RET});
    pad_to(target);
    ld_imm(13, 8'h01);
    emit({4'h0, OP_EXIT});
    load_program();
    run_to_halt();
    check_regs();
    expect_mem(STACK_BASE, byte_t'(ret_addr[11:8]), "stack[0] high");
    expect_mem(STACK_BASE + 12'd1, ret_addr[7:0], "stack[0] low");
    end_test("control_flow", err0);
  endtask

  task automatic test_drawing();
    int   err0;
    int   i;
    logic hit;
    err0 = errors;
    sprite[0] = byte_t'($random(seed)) | 8'h81;
    sprite[1] = byte_t'($random(seed)) | 8'h81;
    host_write_byte(SPRITE_ADDR, sprite[0]);
    host_write_byte(SPRITE_ADDR + 12'd1, sprite[1]);
    prog.delete();
    clear_regs();
    emit({4'h0, OP_CLS});
    emit({4'hA, SPRITE_ADDR});
    ld_imm(2, 8'd61);
    ld_imm(3, 8'd31);
    emit(16'hD232);
    emit({4'h0, OP_EXIT});
    load_program();
    run_to_halt();
    for (i = 0; i < SCREEN_BYTES; i++) begin
      scr_model[i] = 8'h00;
    end
    draw_model(v[2], v[3], hit);
    check_screen();
    expect_mem(REG_BASE + 12'hF, byte_t'(hit), "VF after first draw");
    // Same sprite again without CLS
    prog.delete();
    emit({4'hA, SPRITE_ADDR});
    emit(16'hD232);
    emit({4'h0, OP_EXIT});
    load_program();
    run_to_halt();
    draw_model(v[2], v[3], hit);
    check_screen();
    expect_mem(REG_BASE + 12'hF, byte_t'(hit), "VF after second draw");
    end_test("drawing", err0);
  endtask

  task automatic test_start_and_arbitration();
    int    err0;
    byte_t probe;
    byte_t got;
    err0 = errors;
    prog.delete();
    clear_regs();
    emit(16'h7001);
    emit({4'h0, OP_EXIT});
    load_program();
    run_to_halt();
    v[0] = v[0] + 8'd1;
    expect_mem(REG_BASE, v[0], "V0 after first run");
    run_to_halt();
    v[0] = v[0] + 8'd1;
    expect_mem(REG_BASE, v[0], "V0 after rerun");
    check_flag("halted", halted, 1'b1);

    probe = byte_t'($random(seed));
    host_write_byte(PROBE_ADDR, probe);
    prog.delete();
    clear_regs();
    // Count V0 up to 0x40 while a host read overlaps
    ld_imm(0, 8'h00);
    emit(16'h7001);
    emit(16'h3040);
    emit(16'h1202);
    emit({4'h0, OP_EXIT});
    load_program();
    pulse_start();
    host_read_byte(PROBE_ADDR, got);
    check_byte("probe byte", got, probe);
    check_flag("halted during host read", halted, 1'b0);
    wait_halt();
    v[0] = 8'h40;
    expect_mem(REG_BASE, v[0], "V0 after loop");
    end_test("start_and_arbitration", err0);
  endtask

  initial begin
    arst_n     = 1'b0;
    start      = 1'b0;
    host_valid = 1'b0;
    host_write = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    repeat (3) @(negedge clk);
    arst_n = 1'b1;

    test_host_port();
    test_arithmetic();
    test_control_flow();
    test_drawing();
    test_start_and_arbitration();

    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
